// File: rv_pkg.sv
//##############################
// widths, encodings and pipeline
// register structs of the core
//##############################
package rv_pkg;

    // data and address word
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    // word index on the program load port
    typedef logic [14:0] imem_addr_t;

    // major opcodes the core keeps
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    // add must stay zero, a cleared ctrl is a bubble
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // branch funct3 codes
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_func_e;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } res_src_e;

    // addi x0,x0,0
    localparam xlen_t NOP_INSN  = 32'h0000_0013;
    // io window sits above the 1 KB data memory
    localparam xlen_t LEDR_ADDR = 32'h0000_0700;
    localparam xlen_t SW_ADDR   = 32'h0000_0710;

    typedef struct packed {
        logic       valid;
        imem_addr_t addr;
        xlen_t      insn;
    } imem_wr_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     op1_pc;
        logic     op2_imm;
        logic     br_unsigned;
        logic     branch;
        logic     jump;
        logic     jalr;
        logic     mem_write;
        logic     mem_read;
        logic     rd_write;
        res_src_e res_src;
    } ctrl_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        reg_addr_t rd;
        logic [2:0] funct3;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        xlen_t     pc4;
        xlen_t     alu_res;
        xlen_t     store_data;
        reg_addr_t rd;
        logic      mem_write;
        logic      mem_read;
        logic      rd_write;
        res_src_e  res_src;
    } ex_mem_t;

    typedef struct packed {
        xlen_t     pc4;
        xlen_t     alu_res;
        xlen_t     load_data;
        reg_addr_t rd;
        logic      rd_write;
        res_src_e  res_src;
    } mem_wb_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } redirect_t;

    // one pending write of a later stage
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
    } haz_src_t;

    typedef struct packed {
        haz_src_t ex;
        haz_src_t mem;
        haz_src_t wb;
    } hazard_t;

endpackage

// File: register_file.sv
//##############################
// 32 x 32 register file
//##############################
`timescale 1ns/100ps

module register_file (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::xlen_t     i_rd_data,
    input  logic              i_rd_en,
    output rv_pkg::xlen_t     o_rs1_data,
    output rv_pkg::xlen_t     o_rs2_data
);

    rv_pkg::xlen_t regs [32];

    // x0 never written so it reads zero
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_en && i_rd != '0) begin
            regs[i_rd] <= i_rd_data;
        end
    end

    // no bypass, new value shows next cycle
    assign o_rs1_data = regs[i_rs1];
    assign o_rs2_data = regs[i_rs2];

endmodule

// File: fetch_unit.sv
//##############################
// pc, program memory, fetch reg
//##############################
`timescale 1ns/100ps

module fetch_unit #(
    parameter int IMEM_WORDS = 256
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::imem_wr_t  i_imem_wr,
    input  logic              i_stall,
    input  rv_pkg::redirect_t i_redirect,
    output rv_pkg::xlen_t     o_insn,
    output rv_pkg::xlen_t     o_pc,
    output rv_pkg::xlen_t     o_fetch_pc
);

    localparam int IW = $clog2(IMEM_WORDS);

    rv_pkg::xlen_t imem [IMEM_WORDS];
    rv_pkg::xlen_t pc;
    rv_pkg::xlen_t fetch_insn;

    // load port, live in any reset state
    always_ff @(posedge i_clk) begin
        if (i_imem_wr.valid) begin
            imem[i_imem_wr.addr[IW-1:0]] <= i_imem_wr.insn;
        end
    end

    // async read by word index
    assign fetch_insn = imem[pc[IW+1:2]];
    assign o_fetch_pc = pc;

    // redirect wins over stall
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            pc <= '0;
        end else if (i_redirect.taken) begin
            pc <= i_redirect.target;
        end else if (!i_stall) begin
            pc <= pc + 32'd4;
        end
    end

    // if/id register, flushed to a nop on redirect
    always_ff @(posedge i_clk) begin
        if (!i_reset || i_redirect.taken) begin
            o_insn <= rv_pkg::NOP_INSN;
            o_pc   <= '0;
        end else if (!i_stall) begin
            o_insn <= fetch_insn;
            o_pc   <= pc;
        end
    end

endmodule

// File: decode_unit.sv
//##############################
// decoder, immediates, stall
// detection and id/ex register
//##############################
`timescale 1ns/100ps

module decode_unit (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::xlen_t     i_insn,
    input  rv_pkg::xlen_t     i_pc,
    input  rv_pkg::redirect_t i_redirect,
    input  rv_pkg::hazard_t   i_hazard,
    input  rv_pkg::reg_addr_t i_wb_rd,
    input  rv_pkg::xlen_t     i_wb_data,
    input  logic              i_wb_en,
    output rv_pkg::id_ex_t    o_id_ex,
    output logic              o_stall,
    output logic              o_insn_vld
);

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::xlen_t     rs1_data;
    rv_pkg::xlen_t     rs2_data;
    rv_pkg::xlen_t     imm;
    rv_pkg::ctrl_t     ctrl;
    logic [2:0]        funct3;

    // funct3 plus funct7 bit 30 to alu op
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    // pending nonzero write to one of our sources
    function automatic logic hit(input rv_pkg::haz_src_t h, input rv_pkg::reg_addr_t a,
                                 input rv_pkg::reg_addr_t b);
        return h.valid && (h.rd != '0) && (h.rd == a || h.rd == b);
    endfunction

    assign rs1    = i_insn[19:15];
    assign rs2    = i_insn[24:20];
    assign funct3 = i_insn[14:12];

    register_file register_file_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (i_wb_rd),
        .i_rd_data  (i_wb_data),
        .i_rd_en    (i_wb_en),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    always_comb begin
        // unknown opcodes keep this side-effect free set
        ctrl       = '0;
        imm        = {{20{i_insn[31]}}, i_insn[31:20]};
        o_insn_vld = 1'b1;
        case (i_insn[6:0])
            rv_pkg::OPC_OP: begin
                ctrl.alu_op   = alu_sel(funct3, i_insn[30]);
                ctrl.rd_write = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                // only srai uses bit 30, addi never subtracts
                ctrl.alu_op   = alu_sel(funct3, i_insn[30] && funct3 == 3'b101);
                ctrl.op2_imm  = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                imm           = {i_insn[31:12], 12'b0};
                ctrl.alu_op   = i_insn[5] ? rv_pkg::ALU_PASS_B : rv_pkg::ALU_ADD;
                ctrl.op1_pc   = !i_insn[5];
                ctrl.op2_imm  = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                imm = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                       i_insn[11:8], 1'b0};
                ctrl.branch      = 1'b1;
                ctrl.br_unsigned = funct3[1];
            end
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: begin
                if (i_insn[3]) begin
                    imm = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                           i_insn[30:21], 1'b0};
                end
                // jalr adds rs1 + imm in the alu
                ctrl.jump     = 1'b1;
                ctrl.jalr     = !i_insn[3];
                ctrl.op2_imm  = 1'b1;
                ctrl.rd_write = 1'b1;
                ctrl.res_src  = rv_pkg::RES_PC4;
            end
            rv_pkg::OPC_LOAD: begin
                ctrl.op2_imm  = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.rd_write = 1'b1;
                ctrl.res_src  = rv_pkg::RES_MEM;
            end
            rv_pkg::OPC_STORE: begin
                imm            = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
                ctrl.op2_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: o_insn_vld = 1'b0;
        endcase
    end

    // no forwarding, wait for every older writer of rs1/rs2
    assign o_stall = hit(i_hazard.ex, rs1, rs2) || hit(i_hazard.mem, rs1, rs2) ||
                     hit(i_hazard.wb, rs1, rs2);

    // bubble on stall or redirect
    always_ff @(posedge i_clk) begin
        if (!i_reset || i_redirect.taken || o_stall) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.pc       <= i_pc;
            o_id_ex.rs1_data <= rs1_data;
            o_id_ex.rs2_data <= rs2_data;
            o_id_ex.imm      <= imm;
            o_id_ex.rd       <= i_insn[11:7];
            o_id_ex.funct3   <= funct3;
            o_id_ex.ctrl     <= ctrl;
        end
    end

endmodule

// File: execute_unit.sv
//##############################
// alu, branch resolve, redirect
// and ex/mem register
//##############################
`timescale 1ns/100ps

module execute_unit (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::id_ex_t    i_id_ex,
    output rv_pkg::ex_mem_t   o_ex_mem,
    output rv_pkg::redirect_t o_redirect,
    output rv_pkg::haz_src_t  o_hazard_ex,
    output logic              o_ctrl
);

    rv_pkg::xlen_t op1;
    rv_pkg::xlen_t op2;
    rv_pkg::xlen_t alu_res;
    logic [4:0]    shamt;
    logic          br_eq;
    logic          br_lt;
    logic          br_cond;

    // operand muxes
    assign op1   = i_id_ex.ctrl.op1_pc ? i_id_ex.pc : i_id_ex.rs1_data;
    assign op2   = i_id_ex.ctrl.op2_imm ? i_id_ex.imm : i_id_ex.rs2_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            rv_pkg::ALU_SUB:    alu_res = op1 - op2;
            rv_pkg::ALU_SLL:    alu_res = op1 << shamt;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU:   alu_res = {31'b0, op1 < op2};
            rv_pkg::ALU_XOR:    alu_res = op1 ^ op2;
            rv_pkg::ALU_SRL:    alu_res = op1 >> shamt;
            rv_pkg::ALU_SRA:    alu_res = $signed(op1) >>> shamt;
            rv_pkg::ALU_OR:     alu_res = op1 | op2;
            rv_pkg::ALU_AND:    alu_res = op1 & op2;
            rv_pkg::ALU_PASS_B: alu_res = op2;
            default:            alu_res = op1 + op2;
        endcase
    end

    // branch compare on the raw register values
    assign br_eq = i_id_ex.rs1_data == i_id_ex.rs2_data;
    assign br_lt = i_id_ex.ctrl.br_unsigned ? (i_id_ex.rs1_data < i_id_ex.rs2_data) :
                   ($signed(i_id_ex.rs1_data) < $signed(i_id_ex.rs2_data));

    always_comb begin
        case (i_id_ex.funct3)
            rv_pkg::BR_BEQ:                 br_cond = br_eq;
            rv_pkg::BR_BNE:                 br_cond = !br_eq;
            rv_pkg::BR_BLT, rv_pkg::BR_BLTU: br_cond = br_lt;
            rv_pkg::BR_BGE, rv_pkg::BR_BGEU: br_cond = !br_lt;
            default:                        br_cond = 1'b0;
        endcase
    end

    // jalr target is rs1+imm with bit 0 cleared
    assign o_redirect.taken  = i_id_ex.ctrl.jump || (i_id_ex.ctrl.branch && br_cond);
    assign o_redirect.target = i_id_ex.ctrl.jalr ? {alu_res[31:1], 1'b0} :
                               i_id_ex.pc + i_id_ex.imm;

    assign o_hazard_ex.valid = i_id_ex.ctrl.rd_write;
    assign o_hazard_ex.rd    = i_id_ex.rd;
    assign o_ctrl            = i_id_ex.ctrl.branch || i_id_ex.ctrl.jump;

    // the branch itself moves on, only younger slots flush
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.pc4        <= i_id_ex.pc + 32'd4;
            o_ex_mem.alu_res    <= alu_res;
            o_ex_mem.store_data <= i_id_ex.rs2_data;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.mem_write  <= i_id_ex.ctrl.mem_write;
            o_ex_mem.mem_read   <= i_id_ex.ctrl.mem_read;
            o_ex_mem.rd_write   <= i_id_ex.ctrl.rd_write;
            o_ex_mem.res_src    <= i_id_ex.ctrl.res_src;
        end
    end

endmodule

// File: result_unit.sv
//##############################
// data memory, io, mem/wb reg
// and writeback select
//##############################
`timescale 1ns/100ps

module result_unit #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::ex_mem_t   i_ex_mem,
    input  rv_pkg::xlen_t     i_io_sw,
    output rv_pkg::xlen_t     o_io_ledr,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::xlen_t     o_wb_data,
    output logic              o_wb_en,
    output rv_pkg::haz_src_t  o_hazard_mem,
    output rv_pkg::haz_src_t  o_hazard_wb
);

    localparam int DW = $clog2(DMEM_WORDS);

    rv_pkg::xlen_t   dmem [DMEM_WORDS];
    rv_pkg::xlen_t   load_data;
    rv_pkg::mem_wb_t mem_wb;
    logic            is_led;
    logic            is_sw;

    // io decode on the full byte address
    assign is_led = i_ex_mem.alu_res == rv_pkg::LEDR_ADDR;
    assign is_sw  = i_ex_mem.alu_res == rv_pkg::SW_ADDR;

    // word stores only
    always_ff @(posedge i_clk) begin
        if (i_ex_mem.mem_write && !is_led && !is_sw) begin
            dmem[i_ex_mem.alu_res[DW+1:2]] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            o_io_ledr <= '0;
        end else if (i_ex_mem.mem_write && is_led) begin
            o_io_ledr <= i_ex_mem.store_data;
        end
    end

    always_comb begin
        load_data = '0;
        if (i_ex_mem.mem_read) begin
            if (is_sw) begin
                load_data = i_io_sw;
            end else if (is_led) begin
                load_data = o_io_ledr;
            end else begin
                load_data = dmem[i_ex_mem.alu_res[DW+1:2]];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.pc4       <= i_ex_mem.pc4;
            mem_wb.alu_res   <= i_ex_mem.alu_res;
            mem_wb.load_data <= load_data;
            mem_wb.rd        <= i_ex_mem.rd;
            mem_wb.rd_write  <= i_ex_mem.rd_write;
            mem_wb.res_src   <= i_ex_mem.res_src;
        end
    end

    // writeback mux
    always_comb begin
        case (mem_wb.res_src)
            rv_pkg::RES_MEM: o_wb_data = mem_wb.load_data;
            rv_pkg::RES_PC4: o_wb_data = mem_wb.pc4;
            default:         o_wb_data = mem_wb.alu_res;
        endcase
    end

    assign o_wb_rd            = mem_wb.rd;
    assign o_wb_en            = mem_wb.rd_write;
    assign o_hazard_mem.valid = i_ex_mem.rd_write;
    assign o_hazard_mem.rd    = i_ex_mem.rd;
    assign o_hazard_wb.valid  = mem_wb.rd_write;
    assign o_hazard_wb.rd     = mem_wb.rd;

endmodule

// File: rv_core_top.sv
//##############################
// top of the five-stage core
//##############################
`timescale 1ns/100ps

module rv_core_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  rv_pkg::imem_wr_t i_imem_wr,
    input  rv_pkg::xlen_t    i_io_sw,
    output rv_pkg::xlen_t    o_io_ledr,
    output rv_pkg::xlen_t    o_pc_debug,
    output logic             o_insn_vld,
    output logic             o_ctrl,
    output logic             o_mispred
);

    rv_pkg::xlen_t     if_insn;
    rv_pkg::xlen_t     if_pc;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::redirect_t redirect;
    rv_pkg::hazard_t   hazard;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::xlen_t     wb_data;
    logic              wb_en;
    logic              stall;

    // mispredict flag is just the taken redirect
    assign o_mispred = redirect.taken;

    fetch_unit #(
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch_unit_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_imem_wr  (i_imem_wr),
        .i_stall    (stall),
        .i_redirect (redirect),
        .o_insn     (if_insn),
        .o_pc       (if_pc),
        .o_fetch_pc (o_pc_debug)
    );

    decode_unit decode_unit_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_insn     (if_insn),
        .i_pc       (if_pc),
        .i_redirect (redirect),
        .i_hazard   (hazard),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data),
        .i_wb_en    (wb_en),
        .o_id_ex    (id_ex),
        .o_stall    (stall),
        .o_insn_vld (o_insn_vld)
    );

    execute_unit execute_unit_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_id_ex     (id_ex),
        .o_ex_mem    (ex_mem),
        .o_redirect  (redirect),
        .o_hazard_ex (hazard.ex),
        .o_ctrl      (o_ctrl)
    );

    result_unit #(
        .DMEM_WORDS (DMEM_WORDS)
    ) result_unit_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_ex_mem     (ex_mem),
        .i_io_sw      (i_io_sw),
        .o_io_ledr    (o_io_ledr),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data),
        .o_wb_en      (wb_en),
        .o_hazard_mem (hazard.mem),
        .o_hazard_wb  (hazard.wb)
    );

endmodule

// File: tb_rv_core.sv
//##############################
// testbench for the rv32i core
//##############################
`timescale 1ns/100ps

module tb_rv_core;

    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 256;
    localparam int NUM_CASES    = 4;
    // header words then program slot
    localparam int CASE_WORDS   = 32;
    localparam int HDR_WORDS    = 4;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 16;
    localparam int HALF_PERIOD  = 20;
    localparam int DRIVE_DLY    = 2;
    localparam logic [31:0] LFSR_SEED = 32'hd1615ad0;

    logic              i_clk;
    logic              i_reset;
    rv_pkg::imem_wr_t  i_imem_wr;
    rv_pkg::xlen_t     i_io_sw;
    rv_pkg::xlen_t     o_io_ledr;
    rv_pkg::xlen_t     o_pc_debug;
    logic              o_insn_vld;
    logic              o_ctrl;
    logic              o_mispred;

    rv_pkg::xlen_t     case_mem [NUM_CASES*CASE_WORDS];
    logic [31:0]       lfsr_state;

    rv_core_top #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) rv_core_top_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_imem_wr  (i_imem_wr),
        .i_io_sw    (i_io_sw),
        .o_io_ledr  (o_io_ledr),
        .o_pc_debug (o_pc_debug),
        .o_insn_vld (o_insn_vld),
        .o_ctrl     (o_ctrl),
        .o_mispred  (o_mispred)
    );

    // 40 ns clock
    initial begin
        i_clk = 1'b0;
        forever begin
            #HALF_PERIOD i_clk = ~i_clk;
        end
    end

    // galois lfsr with taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per switch bit
    task automatic draw_switches(output rv_pkg::xlen_t value);
        value = '0;
        for (int b = 0; b < 32; b++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input rv_pkg::xlen_t got,
                               input rv_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // inputs change just after the rising edge
    task automatic drive_edge();
        @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    // whole imem rewritten under reset and reset held 8 more cycles
    task automatic load_case(input int c, output rv_pkg::xlen_t expected,
                             output logic [31:0] flags, output int budget);
        int            base;
        int            len;
        rv_pkg::xlen_t sw_val;
        base   = c * CASE_WORDS;
        len    = case_mem[base];
        flags  = case_mem[base+1];
        budget = case_mem[base+3];
        if (len > CASE_WORDS - HDR_WORDS) begin
            fail_run($sformatf("case %0d has a program longer than its slot", c));
        end
        sw_val = '0;
        if (flags[0]) begin
            draw_switches(sw_val);
        end
        expected = case_mem[base+2] + sw_val;
        for (int a = 0; a < IMEM_WORDS + RESET_CYCLES; a++) begin
            drive_edge();
            i_reset = 1'b0;
            i_io_sw = sw_val;
            if (a < IMEM_WORDS) begin
                i_imem_wr.valid = 1'b1;
                i_imem_wr.addr  = rv_pkg::imem_addr_t'(a);
                i_imem_wr.insn  = (a < len) ? case_mem[base+HDR_WORDS+a] : rv_pkg::NOP_INSN;
            end else begin
                i_imem_wr = '0;
            end
        end
        drive_edge();
        i_reset = 1'b1;
    endtask

    task automatic run_case(input int c);
        rv_pkg::xlen_t expected;
        logic [31:0]   flags;
        int            budget;
        int            cycles;
        logic          seen_redirect;
        logic          seen_invalid;
        load_case(c, expected, flags, budget);
        // first sample after release still shows reset state
        @(negedge i_clk);
        check_value($sformatf("case %0d pc after reset", c), o_pc_debug, '0);
        check_value($sformatf("case %0d ledr after reset", c), o_io_ledr, '0);
        check_value($sformatf("case %0d ctrl after reset", c), o_ctrl, '0);
        check_value($sformatf("case %0d mispred after reset", c), o_mispred, '0);
        seen_redirect = 1'b0;
        seen_invalid  = 1'b0;
        cycles        = 0;
        while (o_io_ledr !== expected && cycles < budget) begin
            @(negedge i_clk);
            cycles++;
            if (o_mispred) begin
                seen_redirect = 1'b1;
                // a redirect only comes from a branch or jump in execute
                check_value($sformatf("case %0d ctrl with redirect", c), o_ctrl, 1);
            end
            if (!o_insn_vld) begin
                seen_invalid = 1'b1;
            end
        end
        if (o_io_ledr !== expected) begin
            fail_run($sformatf("case %0d never reached LED value %h within %0d cycles",
                               c, expected, budget));
        end
        // led must stay put while the spin loop runs
        for (int h = 0; h < HOLD_CYCLES; h++) begin
            @(negedge i_clk);
            if (o_mispred) begin
                seen_redirect = 1'b1;
            end
            check_value($sformatf("case %0d ledr hold", c), o_io_ledr, expected);
        end
        if (flags[1]) begin
            check_value($sformatf("case %0d mispred seen", c), seen_redirect, 1);
        end
        check_value($sformatf("case %0d unknown opcode in decode", c), seen_invalid, flags[2]);
        $display("case %0d done after %0d cycles, led %h", c, cycles, o_io_ledr);
    endtask

    initial begin
        i_reset    = 1'b0;
        i_imem_wr  = '0;
        i_io_sw    = '0;
        lfsr_state = LFSR_SEED;
        $readmemh("program_cases.mem", case_mem);
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: program_cases.mem
// per case 32 words: length, flags, expected led, cycle budget, then 28 program words
// flags: bit0 adds the switch value, bit1 needs a redirect, bit2 holds an unknown opcode
// dependent alu and lui/auipc chain, led = 0x13374778
0000000D 00000000 13374778 000000C8
123450B7 67808093 00001117 402081B3 00419213 001242B3 0042D313 003363B3 00712433 008384B3
70000513 00952023 0000006F 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
// sw/lw through dmem plus switch load, led = 0x0abcd123 + switches
00000009 00000001 0ABCD123 000000C8
0ABCD0B7 12308093 04000113 00112423 00812183 71002203 004182B3 70502023 0000006F 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
// six branch kinds in a counted loop with jal/jalr call, led = 7
00000013 00000002 00000007 00000320
00000093 00700113 FFF00193 00100213 034002EF 0041C463 06408093 0041EE63 0041F463 06408093
00325463 06408093 00208663 FC209EE3 06408093 70102023 0000006F 00108093 00028067 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
// unknown opcode before the final store, led = 0x0002a55a
00000006 00000004 0002A55A 000000C8
2A500093 00809093 05A0E093 0010808B 70102023 0000006F 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013

// File: flist.f
rv_pkg.sv
register_file.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
rv_core_top.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

dependencies: {}

sources:
  - rv_pkg.sv
  - register_file.sv
  - fetch_unit.sv
  - decode_unit.sv
  - execute_unit.sv
  - result_unit.sv
  - rv_core_top.sv
  - target: test
    files:
      - tb_rv_core.sv
